//--- hdl/cp0Pkg.sv
`default_nettype none

package cp0Pkg;

    localparam int RegAddrW = 8;
    localparam int DataW    = 32;

    // register addresses are {rd, sel}
    localparam logic [RegAddrW-1:0] ADDR_BADVADDR = {5'd8, 3'd0};
    localparam logic [RegAddrW-1:0] ADDR_COUNT    = {5'd9, 3'd0};
    localparam logic [RegAddrW-1:0] ADDR_COMPARE  = {5'd11, 3'd0};
    localparam logic [RegAddrW-1:0] ADDR_STATUS   = {5'd12, 3'd0};
    localparam logic [RegAddrW-1:0] ADDR_CAUSE    = {5'd13, 3'd0};
    localparam logic [RegAddrW-1:0] ADDR_EPC      = {5'd14, 3'd0};
    localparam logic [RegAddrW-1:0] ADDR_CONFIG   = {5'd16, 3'd0};
    localparam logic [RegAddrW-1:0] ADDR_CONFIG1  = {5'd16, 3'd1};

    localparam logic [4:0] EXC_INT  = 5'd0;
    localparam logic [4:0] EXC_ADEL = 5'd4;
    localparam logic [4:0] EXC_SYS  = 5'd8;
    localparam logic [4:0] EXC_BP   = 5'd9;
    localparam logic [4:0] EXC_RI   = 5'd10;
    localparam logic [4:0] EXC_OV   = 5'd12;

    localparam logic [DataW-1:0] EXC_VECTOR    = 32'hBFC0_0380; // bootstrap vector, BEV stays 1

    localparam logic [DataW-1:0] STATUS_RESET  = 32'h0040_0000; // BEV only
    localparam logic [DataW-1:0] CONFIG_RESET  = 32'h8000_0083; // M, MT=1, K0 cacheable
    localparam logic [DataW-1:0] CONFIG1_RESET = 32'h2099_4C80; // cache geometry, read only

    typedef enum logic [3:0] {
        opMfc0,
        opMtc0,
        opEret,
        opSyscall,
        opBreak,
        opReserved,
        opOverflow,
        opAdel
    } opKind;

    typedef struct packed {
        opKind                kind;
        logic [DataW-1:0]     pc;
        logic                 inDelaySlot;
        logic [RegAddrW-1:0]  regAddr;
        logic [DataW-1:0]     wrData;
        logic [DataW-1:0]     badAddr;
    } cp0Req;

    typedef struct packed {
        logic [DataW-1:0]     pc;
        logic                 inDelaySlot;
        logic                 isRead;
        logic [RegAddrW-1:0]  rdSel;
        logic                 wrCount;
        logic                 wrCompare;
        logic                 wrStatus;
        logic                 wrCause;
        logic                 wrEpc;
        logic                 wrConfig;
        logic [DataW-1:0]     wrData;
        logic                 isEret;
        logic                 excValid;
        logic [4:0]           excCode;
        logic                 badAddrValid;
        logic [DataW-1:0]     badAddr;
    } cp0Op;

    typedef struct packed {
        logic                 wrCount;
        logic                 wrCompare;
        logic                 wrStatus;
        logic                 wrCause;
        logic                 wrEpc;
        logic                 wrConfig;
        logic [DataW-1:0]     wrData;
        logic                 isRead;
        logic [RegAddrW-1:0]  rdSel;
        logic                 takeExc;
        logic [4:0]           excCode;
        logic                 bd;
        logic [DataW-1:0]     epcValue;
        logic                 epcWrite;
        logic                 badAddrValid;
        logic [DataW-1:0]     badAddr;
        logic                 redirectValid;
        logic [DataW-1:0]     redirectPc;
    } cp0Update;

endpackage

`default_nettype wire

//--- hdl/cp0Decode.sv
`timescale 1ns/1ps
`default_nettype none

module cp0Decode (
    input  logic          clk,
    input  logic          rst,
    input  logic          reqValid,
    input  cp0Pkg::cp0Req req,
    output logic          opValid,
    output cp0Pkg::cp0Op  op
);

    cp0Pkg::cp0Op opNext;
    logic         implemented;

    always_comb begin
        case (req.regAddr)
            cp0Pkg::ADDR_BADVADDR,
            cp0Pkg::ADDR_COUNT,
            cp0Pkg::ADDR_COMPARE,
            cp0Pkg::ADDR_STATUS,
            cp0Pkg::ADDR_CAUSE,
            cp0Pkg::ADDR_EPC,
            cp0Pkg::ADDR_CONFIG,
            cp0Pkg::ADDR_CONFIG1: implemented = 1'b1;
            default:              implemented = 1'b0;
        endcase
    end

    always_comb begin
        opNext             = '0;
        opNext.pc          = req.pc;
        opNext.inDelaySlot = req.inDelaySlot;
        opNext.wrData      = req.wrData;
        opNext.badAddr     = req.badAddr;
        case (req.kind)
            cp0Pkg::opMfc0: begin
                opNext.isRead = 1'b1;
                opNext.rdSel  = implemented ? req.regAddr : '0; // holes read as zero
            end
            cp0Pkg::opMtc0: begin
                case (req.regAddr)
                    cp0Pkg::ADDR_COUNT:   opNext.wrCount   = 1'b1;
                    cp0Pkg::ADDR_COMPARE: opNext.wrCompare = 1'b1;
                    cp0Pkg::ADDR_STATUS:  opNext.wrStatus  = 1'b1;
                    cp0Pkg::ADDR_CAUSE:   opNext.wrCause   = 1'b1;
                    cp0Pkg::ADDR_EPC:     opNext.wrEpc     = 1'b1;
                    cp0Pkg::ADDR_CONFIG:  opNext.wrConfig  = 1'b1;
                    default: ; // BadVAddr, Config1 and holes are dropped
                endcase
            end
            cp0Pkg::opEret: opNext.isEret = 1'b1;
            cp0Pkg::opSyscall: begin
                opNext.excValid = 1'b1;
                opNext.excCode  = cp0Pkg::EXC_SYS;
            end
            cp0Pkg::opBreak: begin
                opNext.excValid = 1'b1;
                opNext.excCode  = cp0Pkg::EXC_BP;
            end
            cp0Pkg::opReserved: begin
                opNext.excValid = 1'b1;
                opNext.excCode  = cp0Pkg::EXC_RI;
            end
            cp0Pkg::opOverflow: begin
                opNext.excValid = 1'b1;
                opNext.excCode  = cp0Pkg::EXC_OV;
            end
            cp0Pkg::opAdel: begin
                opNext.excValid     = 1'b1;
                opNext.excCode      = cp0Pkg::EXC_ADEL;
                opNext.badAddrValid = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            opValid <= 1'b0;
        end else begin
            opValid <= reqValid;
        end
    end

    always_ff @(posedge clk) begin
        op <= opNext;
    end

endmodule

`default_nettype wire

//--- hdl/excArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module excArbiter (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     opValid,
    input  cp0Pkg::cp0Op             op,
    input  logic                     intPending,
    input  logic                     exl,
    input  logic [cp0Pkg::DataW-1:0] epc,
    output logic                     updValid,
    output cp0Pkg::cp0Update         upd
);

    cp0Pkg::cp0Update updNext;
    logic             takeExc;

    // a pending interrupt wins over whatever the operation does
    assign takeExc = op.excValid | intPending;

    always_comb begin
        updNext = '0;

        // an exception cancels the operation's own effects
        updNext.wrCount   = op.wrCount & ~takeExc;
        updNext.wrCompare = op.wrCompare & ~takeExc;
        updNext.wrStatus  = op.wrStatus & ~takeExc;
        updNext.wrCause   = op.wrCause & ~takeExc;
        updNext.wrEpc     = op.wrEpc & ~takeExc;
        updNext.wrConfig  = op.wrConfig & ~takeExc;
        updNext.wrData    = op.wrData;
        updNext.isRead    = op.isRead & ~takeExc;
        updNext.rdSel     = op.rdSel;

        updNext.takeExc = takeExc;
        updNext.excCode = intPending ? cp0Pkg::EXC_INT : op.excCode;
        updNext.bd      = op.inDelaySlot;

        // restart at the branch when the victim sits in a delay slot
        updNext.epcValue = op.inDelaySlot ? op.pc - 32'd4 : op.pc;
        updNext.epcWrite = takeExc & ~exl; // nested exception keeps EPC and BD

        updNext.badAddrValid = op.badAddrValid & ~intPending;
        updNext.badAddr      = op.badAddr;

        updNext.redirectValid = takeExc | (op.isEret & ~takeExc);
        updNext.redirectPc    = takeExc ? cp0Pkg::EXC_VECTOR : epc; // eret returns to EPC
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            updValid <= 1'b0;
        end else begin
            updValid <= opValid;
        end
    end

    always_ff @(posedge clk) begin
        upd <= updNext;
    end

endmodule

`default_nettype wire

//--- hdl/cp0Regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0Regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [5:0]               interrupt,
    input  logic                     updValid,
    input  cp0Pkg::cp0Update         upd,
    output logic                     rdValid,
    output logic [cp0Pkg::DataW-1:0] rdData,
    output logic                     redirectValid,
    output logic [cp0Pkg::DataW-1:0] redirectPc,
    output logic                     intPending,
    output logic                     exl,
    output logic [cp0Pkg::DataW-1:0] epc
);

    logic [cp0Pkg::DataW-1:0] badVAddr;
    logic [cp0Pkg::DataW:0]   count;    // visible count is count[32:1]
    logic [cp0Pkg::DataW-1:0] compare;
    logic [cp0Pkg::DataW-1:0] status;
    logic [cp0Pkg::DataW-1:0] cause;
    logic [cp0Pkg::DataW-1:0] epcReg;
    logic [cp0Pkg::DataW-1:0] config0;
    logic [cp0Pkg::DataW-1:0] rdNext;
    logic                     isEret;

    assign exl = status[1];
    assign epc = epcReg;

    // IP masked by IM, gated by IE and EXL
    assign intPending = (|(cause[15:8] & status[15:8])) & status[0] & ~status[1];

    // a redirect without an exception can only come from eret
    assign isEret = upd.redirectValid & ~upd.takeExc;

    always_ff @(posedge clk) begin
        if (rst) begin
            count   <= '0;
            compare <= '0;
            status  <= cp0Pkg::STATUS_RESET;
            cause   <= '0;
            config0 <= cp0Pkg::CONFIG_RESET;
        end else begin
            count        <= count + 33'd1;
            cause[15:10] <= {cause[30] | interrupt[5], interrupt[4:0]}; // IP7 shares TI

            if (compare != '0 && count[32:1] == compare) begin
                cause[30] <= 1'b1;
            end

            if (updValid) begin
                if (upd.wrCount) begin
                    count <= {upd.wrData, 1'b0};
                end
                if (upd.wrCompare) begin
                    compare   <= upd.wrData;
                    cause[30] <= 1'b0;       // ack timer
                end
                if (upd.wrStatus) begin
                    status[15:8] <= upd.wrData[15:8];
                    status[1:0]  <= upd.wrData[1:0];
                end
                if (upd.wrCause) begin
                    cause[9:8] <= upd.wrData[9:8]; // software interrupts
                end
                if (upd.wrConfig) begin
                    config0[2:0] <= upd.wrData[2:0];
                end

                if (upd.takeExc) begin
                    cause[6:2] <= upd.excCode;
                    status[1]  <= 1'b1;
                    if (upd.epcWrite) begin
                        cause[31] <= upd.bd;
                    end
                end else if (isEret) begin
                    status[1] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (updValid && upd.wrEpc) begin
            epcReg <= upd.wrData;
        end else if (updValid && upd.takeExc && upd.epcWrite) begin
            epcReg <= upd.epcValue;
        end
        if (updValid && upd.takeExc && upd.badAddrValid) begin
            badVAddr <= upd.badAddr;
        end
    end

    always_comb begin
        case (upd.rdSel)
            cp0Pkg::ADDR_BADVADDR: rdNext = badVAddr;
            cp0Pkg::ADDR_COUNT:    rdNext = count[32:1];
            cp0Pkg::ADDR_COMPARE:  rdNext = compare;
            cp0Pkg::ADDR_STATUS:   rdNext = status;
            cp0Pkg::ADDR_CAUSE:    rdNext = cause;
            cp0Pkg::ADDR_EPC:      rdNext = epcReg;
            cp0Pkg::ADDR_CONFIG:   rdNext = config0;
            cp0Pkg::ADDR_CONFIG1:  rdNext = cp0Pkg::CONFIG1_RESET;
            default:               rdNext = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdValid       <= 1'b0;
            redirectValid <= 1'b0;
        end else begin
            rdValid       <= updValid & upd.isRead;
            redirectValid <= updValid & upd.redirectValid;
        end
    end

    // read data shows the state before this commit
    always_ff @(posedge clk) begin
        rdData     <= rdNext;
        redirectPc <= upd.redirectPc;
    end

endmodule

`default_nettype wire

//--- hdl/cp0Top.sv
`timescale 1ns/1ps
`default_nettype none

module cp0Top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [5:0]               interrupt,
    input  logic                     reqValid,
    input  cp0Pkg::cp0Req            req,
    output logic                     rdValid,
    output logic [cp0Pkg::DataW-1:0] rdData,
    output logic                     redirectValid,
    output logic [cp0Pkg::DataW-1:0] redirectPc,
    output logic                     intPending
);

    logic                     opValid;
    cp0Pkg::cp0Op             op;
    logic                     updValid;
    cp0Pkg::cp0Update         upd;
    logic                     exl;
    logic [cp0Pkg::DataW-1:0] epc;

    cp0Decode decode (
        .clk      (clk),
        .rst      (rst),
        .reqValid (reqValid),
        .req      (req),
        .opValid  (opValid),
        .op       (op)
    );

    excArbiter arbiter (
        .clk        (clk),
        .rst        (rst),
        .opValid    (opValid),
        .op         (op),
        .intPending (intPending),
        .exl        (exl),
        .epc        (epc),
        .updValid   (updValid),
        .upd        (upd)
    );

    cp0Regs regs (
        .clk           (clk),
        .rst           (rst),
        .interrupt     (interrupt),
        .updValid      (updValid),
        .upd           (upd),
        .rdValid       (rdValid),
        .rdData        (rdData),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .intPending    (intPending),
        .exl           (exl),
        .epc           (epc)
    );

endmodule

`default_nettype wire

//--- sim/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

endmodule

`default_nettype wire

//--- sim/cp0Tb.sv
`timescale 1ns/1ps
`default_nettype none

module cp0Tb;

    logic                     clk;
    logic                     rst;
    logic [5:0]               interrupt;
    logic                     reqValid;
    cp0Pkg::cp0Req            req;
    logic                     rdValid;
    logic [cp0Pkg::DataW-1:0] rdData;
    logic                     redirectValid;
    logic [cp0Pkg::DataW-1:0] redirectPc;
    logic                     intPending;

    logic [31:0]   seed     = 32'd86202;
    int            cycle    = 0;
    logic          skipData = 1'b0;
    logic [31:0]   lastRd;
    int            lastCycle;
    cp0Pkg::opKind excKinds [5] = '{cp0Pkg::opSyscall, cp0Pkg::opBreak, cp0Pkg::opReserved,
                                    cp0Pkg::opOverflow, cp0Pkg::opAdel};

    // expected register fields
    logic [31:0] mStatus;
    logic [31:0] mCause;
    logic [31:0] mEpc;
    logic [31:0] mCompare;
    logic [31:0] mConfig;
    logic [31:0] mBadVAddr;
    logic        mTi;

    tbClock clockGen (.clk(clk));

    cp0Top UUT (
        .clk           (clk),
        .rst           (rst),
        .interrupt     (interrupt),
        .reqValid      (reqValid),
        .req           (req),
        .rdValid       (rdValid),
        .rdData        (rdData),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .intPending    (intPending)
    );

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic logic [31:0] rndPc();
        logic [31:0] r;
        r = nextRand();
        return {r[31:2], 2'b00};
    endfunction

    function automatic logic [31:0] causeView();
        logic [31:0] c;
        c        = mCause;
        c[30]    = mTi;
        c[15:10] = {mTi | interrupt[5], interrupt[4:0]}; // IP7 carries the timer too
        return c;
    endfunction

    function automatic logic modelPending();
        logic [31:0] c;
        c = causeView();
        return (|(c[15:8] & mStatus[15:8])) & mStatus[0] & ~mStatus[1];
    endfunction

    function automatic logic [31:0] modelRead(input logic [7:0] addr);
        case (addr)
            cp0Pkg::ADDR_BADVADDR: return mBadVAddr;
            cp0Pkg::ADDR_COMPARE:  return mCompare;
            cp0Pkg::ADDR_STATUS:   return mStatus;
            cp0Pkg::ADDR_CAUSE:    return causeView();
            cp0Pkg::ADDR_EPC:      return mEpc;
            cp0Pkg::ADDR_CONFIG:   return mConfig;
            cp0Pkg::ADDR_CONFIG1:  return cp0Pkg::CONFIG1_RESET;
            default:               return 32'h0;
        endcase
    endfunction

    function automatic void modelWrite(input logic [7:0] addr, input logic [31:0] data);
        case (addr)
            cp0Pkg::ADDR_STATUS: begin
                mStatus[15:8] = data[15:8]; // IM
                mStatus[1:0]  = data[1:0];  // EXL, IE
            end
            cp0Pkg::ADDR_CAUSE:  mCause[9:8] = data[9:8];
            cp0Pkg::ADDR_EPC:    mEpc = data;
            cp0Pkg::ADDR_COMPARE: begin
                mCompare = data;
                mTi      = 1'b0;
            end
            cp0Pkg::ADDR_CONFIG: mConfig[2:0] = data[2:0];
            default: ;
        endcase
    endfunction

    function automatic logic [4:0] excCodeOf(input cp0Pkg::opKind kind);
        case (kind)
            cp0Pkg::opSyscall:  return cp0Pkg::EXC_SYS;
            cp0Pkg::opBreak:    return cp0Pkg::EXC_BP;
            cp0Pkg::opReserved: return cp0Pkg::EXC_RI;
            cp0Pkg::opOverflow: return cp0Pkg::EXC_OV;
            cp0Pkg::opAdel:     return cp0Pkg::EXC_ADEL;
            default:            return cp0Pkg::EXC_INT;
        endcase
    endfunction

    task automatic failRun(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else failRun($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // one request, checked 3 cycles after it is driven
    task automatic issue(input cp0Pkg::opKind kind, input logic [7:0] addr,
                         input logic [31:0] data, input logic [31:0] pc, input logic slot,
                         input logic [31:0] bad);
        logic        pend;
        logic        expRd;
        logic        expRedir;
        logic [31:0] expData;
        logic [31:0] expPc;
        pend     = modelPending();
        expRd    = 1'b0;
        expRedir = 1'b0;
        expData  = 32'h0;
        expPc    = 32'h0;
        checkEq("intPending", intPending, pend);
        if (pend || (kind != cp0Pkg::opMfc0 && kind != cp0Pkg::opMtc0
                     && kind != cp0Pkg::opEret)) begin
            expRedir    = 1'b1;
            expPc       = cp0Pkg::EXC_VECTOR;
            mCause[6:2] = pend ? cp0Pkg::EXC_INT : excCodeOf(kind);
            if (!mStatus[1]) begin
                mCause[31] = slot;
                mEpc       = slot ? pc - 32'd4 : pc;
            end
            mStatus[1] = 1'b1;
            if (kind == cp0Pkg::opAdel && !pend) mBadVAddr = bad;
        end else if (kind == cp0Pkg::opMfc0) begin
            expRd   = 1'b1;
            expData = modelRead(addr);
        end else if (kind == cp0Pkg::opMtc0) begin
            modelWrite(addr, data);
        end else begin
            expRedir   = 1'b1;
            expPc      = mEpc;
            mStatus[1] = 1'b0;
        end
        req.kind        = kind;
        req.pc          = pc;
        req.inDelaySlot = slot;
        req.regAddr     = addr;
        req.wrData      = data;
        req.badAddr     = bad;
        reqValid        = 1'b1;
        lastCycle       = cycle;
        @(negedge clk);
        reqValid = 1'b0;
        for (int i = 0; i < 2; i++) @(negedge clk);
        checkEq("rdValid", rdValid, expRd);
        checkEq("redirectValid", redirectValid, expRedir);
        if (expRd && !skipData && addr != cp0Pkg::ADDR_COUNT) checkEq("rdData", rdData, expData);
        if (expRedir) checkEq("redirectPc", redirectPc, expPc);
        lastRd = rdData;
        @(negedge clk); // one idle cycle keeps requests four cycles apart
    endtask

    task automatic readReg(input logic [7:0] addr);
        issue(cp0Pkg::opMfc0, addr, 32'h0, rndPc(), 1'b0, 32'h0);
    endtask

    task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
        issue(cp0Pkg::opMtc0, addr, data, rndPc(), 1'b0, 32'h0);
    endtask

    task automatic returnFromExc();
        issue(cp0Pkg::opEret, 8'h0, 32'h0, rndPc(), 1'b0, 32'h0);
    endtask

    task automatic waitPending();
        int i;
        for (i = 0; i < 20 && !intPending; i++) @(negedge clk);
        if (!intPending) failRun("intPending did not rise after the interrupt was enabled");
    endtask

    initial begin
        logic [31:0] c0;
        logic [31:0] c1;
        int          cyc0;
        int          span;
        int          polls;
        rst       = 1'b1;
        interrupt = 6'b0;
        reqValid  = 1'b0;
        req       = '0;
        mStatus   = cp0Pkg::STATUS_RESET;
        mCause    = 32'h0;
        mEpc      = 32'h0;
        mCompare  = 32'h0;
        mConfig   = cp0Pkg::CONFIG_RESET;
        mBadVAddr = 32'h0;
        mTi       = 1'b0;
        for (int i = 0; i < 16; i++) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        readReg(cp0Pkg::ADDR_STATUS);
        readReg(cp0Pkg::ADDR_CAUSE);
        readReg(cp0Pkg::ADDR_CONFIG);
        readReg(cp0Pkg::ADDR_CONFIG1);
        readReg({5'd3, 3'd0}); // hole reads zero

        writeReg(cp0Pkg::ADDR_STATUS, nextRand() & ~32'h3); // keep IE and EXL clear
        writeReg(cp0Pkg::ADDR_CAUSE, nextRand());
        writeReg(cp0Pkg::ADDR_EPC, nextRand());
        writeReg(cp0Pkg::ADDR_COMPARE, nextRand());
        writeReg(cp0Pkg::ADDR_CONFIG, nextRand());
        writeReg(cp0Pkg::ADDR_CONFIG1, nextRand());
        readReg(cp0Pkg::ADDR_STATUS);
        readReg(cp0Pkg::ADDR_CAUSE);
        readReg(cp0Pkg::ADDR_EPC);
        readReg(cp0Pkg::ADDR_COMPARE);
        readReg(cp0Pkg::ADDR_CONFIG);
        readReg(cp0Pkg::ADDR_CONFIG1);

        for (int k = 0; k < 5; k++) begin
            issue(excKinds[k], 8'h0, 32'h0, rndPc(), k[0], nextRand()); // odd ones in a slot
            readReg(cp0Pkg::ADDR_CAUSE);
            readReg(cp0Pkg::ADDR_EPC);
            readReg(cp0Pkg::ADDR_STATUS);
            returnFromExc();
            readReg(cp0Pkg::ADDR_STATUS);
        end
        readReg(cp0Pkg::ADDR_BADVADDR);
        writeReg(cp0Pkg::ADDR_BADVADDR, nextRand());
        readReg(cp0Pkg::ADDR_BADVADDR);

        // nested exception keeps EPC and BD
        issue(cp0Pkg::opSyscall, 8'h0, 32'h0, rndPc(), 1'b0, 32'h0);
        issue(cp0Pkg::opBreak, 8'h0, 32'h0, rndPc(), 1'b1, 32'h0);
        readReg(cp0Pkg::ADDR_EPC);
        readReg(cp0Pkg::ADDR_CAUSE);
        returnFromExc();
        readReg(cp0Pkg::ADDR_STATUS);

        writeReg(cp0Pkg::ADDR_STATUS, 32'h0000_0401); // IE and IM2
        interrupt = 6'b000001;
        waitPending();
        writeReg(cp0Pkg::ADDR_COMPARE, nextRand()); // becomes an interrupt
        readReg(cp0Pkg::ADDR_CAUSE);
        readReg(cp0Pkg::ADDR_COMPARE);
        interrupt = 6'b0;
        returnFromExc();
        writeReg(cp0Pkg::ADDR_CAUSE, 32'h0000_0100); // IP0, still masked
        writeReg(cp0Pkg::ADDR_STATUS, 32'h0000_0101);
        waitPending();
        writeReg(cp0Pkg::ADDR_COMPARE, nextRand());
        readReg(cp0Pkg::ADDR_CAUSE);
        readReg(cp0Pkg::ADDR_COMPARE);
        writeReg(cp0Pkg::ADDR_CAUSE, 32'h0);
        returnFromExc();
        writeReg(cp0Pkg::ADDR_STATUS, 32'h0);

        readReg(cp0Pkg::ADDR_COUNT);
        c0   = lastRd;
        cyc0 = lastCycle;
        writeReg(cp0Pkg::ADDR_COMPARE, c0 + 32'd12);
        skipData = 1'b1;
        polls    = 0;
        do begin
            readReg(cp0Pkg::ADDR_CAUSE);
            polls++;
        end while (!lastRd[30] && polls < 20);
        skipData = 1'b0;
        if (!lastRd[30]) failRun("timer interrupt never showed up in Cause");
        mTi = 1'b1;
        readReg(cp0Pkg::ADDR_CAUSE);
        writeReg(cp0Pkg::ADDR_COMPARE, c0 + 32'h1000); // acknowledges the timer
        readReg(cp0Pkg::ADDR_CAUSE);
        readReg(cp0Pkg::ADDR_COUNT);
        c1   = lastRd;
        span = lastCycle - cyc0;
        assert (c1 >= c0 && (c1 - c0) * 2 + 2 >= span && (c1 - c0) * 2 <= span + 2)
        else failRun($sformatf("[FAIL] Count got 0x%h after 0x%h over %0d cycles", c1, c0, span));

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- cp0Sys.f
hdl/cp0Pkg.sv
hdl/cp0Decode.sv
hdl/excArbiter.sv
hdl/cp0Regs.sv
hdl/cp0Top.sv
sim/tbClock.sv
sim/cp0Tb.sv

//--- Bender.yml
package:
  name: cp0Sys

sources:
  - hdl/cp0Pkg.sv
  - hdl/cp0Decode.sv
  - hdl/excArbiter.sv
  - hdl/cp0Regs.sv
  - hdl/cp0Top.sv
  - target: simulation
    files:
      - sim/tbClock.sv
      - sim/cp0Tb.sv
